// File: filelist.f
rtl/vic_cfg_pkg.sv
rtl/serial_rx.sv
rtl/serial_tx.sv
rtl/cfg_regs.sv
rtl/raster_timing.sv
rtl/vic_link_top.sv
sim/tb_vic_link.sv

// File: rtl/cfg_regs.sv
`timescale 1ns/100ps

module cfg_regs
   import vic_cfg_pkg::*;
(
   input  logic       sys_clock,
   input  logic       rst_n,
   input  logic [7:0] rx_data,
   input  logic       rx_strobe,
   input  logic       tx_busy,
   input  logic       irq_pending_set,   // raster compare hit
   output logic [7:0] tx_data,
   output logic       tx_start,
   output chip_t      chip,
   output raster_y_t  raster_cmp,
   output logic       irq_en,
   output logic       irq
);

   typedef enum logic {PS_CMD, PS_DATA} parse_t;

   parse_t     pstate;
   reg_addr_t  wr_addr;       // address waiting for its data byte
   logic       irq_pending;
   logic       rd_pend;       // one reply held while tx is busy
   logic [7:0] rd_data;
   logic [7:0] rd_value;      // register read mux
   logic       read_now;
   logic       write_now;
   logic       send_ok;
   logic       send_pend;
   logic       send_new;

   assign irq = irq_pending & irq_en;   // level

   assign read_now  = rx_strobe && pstate == PS_CMD && rx_data[CMD_READ_BIT];
   assign write_now = rx_strobe && pstate == PS_DATA;
   // tx_busy lags the start pulse by one clock
   assign send_ok   = !tx_busy && !tx_start;
   assign send_pend = send_ok && rd_pend;
   assign send_new  = send_ok && !rd_pend && read_now;

   always_comb begin
      case (reg_addr_t'(rx_data[6:0]))
         REG_CHIP:      rd_value = {6'd0, chip};
         REG_RASTER_LO: rd_value = raster_cmp[7:0];
         REG_RASTER_HI: rd_value = {irq_en, 6'd0, raster_cmp[8]};
         REG_IRQ:       rd_value = {7'd0, irq_pending};
         default:       rd_value = 8'd0;   // unmapped
      endcase
   end

   always_ff @(posedge sys_clock or negedge rst_n) begin
      if (!rst_n) begin
         pstate      <= PS_CMD;
         wr_addr     <= '0;
         chip        <= CHIP_6569;
         raster_cmp  <= '0;
         irq_en      <= 1'b0;
         irq_pending <= 1'b0;
         rd_pend     <= 1'b0;
         tx_start    <= 1'b0;
      end else begin
         if (rx_strobe) begin
            if (pstate == PS_CMD) begin
               if (!rx_data[CMD_READ_BIT]) begin
                  wr_addr <= rx_data[6:0];
                  pstate  <= PS_DATA;
               end
            end else
               pstate <= PS_CMD;
         end
         if (write_now) begin
            case (wr_addr)
               REG_CHIP:      chip <= chip_t'(rx_data[1:0]);
               REG_RASTER_LO: raster_cmp[7:0] <= rx_data;
               REG_RASTER_HI: begin
                  raster_cmp[8] <= rx_data[0];
                  irq_en        <= rx_data[7];
               end
               default: ;   // unknown address, dropped
            endcase
         end
         // set wins over a clear in the same clock
         if (irq_pending_set)
            irq_pending <= 1'b1;
         else if (write_now && wr_addr == REG_IRQ && rx_data[0])
            irq_pending <= 1'b0;
         tx_start <= send_pend || send_new;
         if (send_pend)
            rd_pend <= read_now;   // a fresh read takes the freed slot
         else if (read_now && !send_new)
            rd_pend <= 1'b1;
      end
   end

   always_ff @(posedge sys_clock) begin
      if (send_pend)
         tx_data <= rd_data;
      else if (send_new)
         tx_data <= rd_value;
      if (read_now && !send_new)
         rd_data <= rd_value;   // value at read time, not at send time
   end

endmodule : cfg_regs

// File: rtl/raster_timing.sv
`timescale 1ns/100ps

module raster_timing
   import vic_cfg_pkg::*;
(
   input  logic      sys_clock,
   input  logic      rst_n,
   input  chip_t     chip,
   input  raster_y_t raster_cmp,
   output logic      hsync,
   output logic      vsync,
   output logic      active,
   output logic      irq_pending_set   // one clock at x=0 of the compare line
);

   raster_x_t x;
   raster_y_t y;
   raster_x_t cpl_q;   // cycles per line of the current frame
   raster_y_t lpf_q;   // lines per frame of the current frame
   logic      frame_start;
   logic      x_last;
   logic      y_last;
   logic      x_in;
   logic      y_in;

   assign frame_start = (x == '0) && (y == '0);
   assign x_last      = (x == cpl_q - 7'd1);
   assign y_last      = (y == lpf_q - 9'd1);

   // display windows
   assign x_in = (x >= ACTIVE_X_FIRST) && (x < ACTIVE_X_FIRST + ACTIVE_X_COUNT);
   assign y_in = (y >= ACTIVE_Y_FIRST) && (y < ACTIVE_Y_FIRST + ACTIVE_Y_COUNT);

   // geometry only follows chip at the top of a frame, so a model change
   // never leaves the counters past a shorter wrap point
   always_ff @(posedge sys_clock or negedge rst_n) begin
      if (!rst_n) begin
         cpl_q <= cycles_per_line(CHIP_6569);   // reset model
         lpf_q <= lines_per_frame(CHIP_6569);
      end else if (frame_start) begin
         cpl_q <= cycles_per_line(chip);
         lpf_q <= lines_per_frame(chip);
      end
   end

   // one raster cycle per clock
   always_ff @(posedge sys_clock or negedge rst_n) begin
      if (!rst_n) begin
         x <= '0;
         y <= '0;
      end else begin
         if (x_last) begin
            x <= '0;
            if (y_last)
               y <= '0;
            else
               y <= y + 9'd1;
         end else
            x <= x + 7'd1;
      end
   end

   // outputs registered, one clock behind the count
   always_ff @(posedge sys_clock or negedge rst_n) begin
      if (!rst_n) begin
         hsync           <= 1'b0;
         vsync           <= 1'b0;
         active          <= 1'b0;
         irq_pending_set <= 1'b0;
      end else begin
         hsync           <= (x < HSYNC_CYCLES);
         vsync           <= (y < VSYNC_LINES);
         active          <= x_in && y_in;
         irq_pending_set <= (x == '0) && (y == raster_cmp);   // once per frame at most
      end
   end

endmodule : raster_timing

// File: rtl/serial_rx.sv
`timescale 1ns/100ps

module serial_rx #(
   parameter int CLKS_PER_BIT = 16
) (
   input  logic       sys_clock,
   input  logic       rst_n,
   input  logic       rx,          // serial line from the MCU
   output logic [7:0] rx_data,
   output logic       rx_strobe    // one clock, at mid stop bit
);

   localparam int CW = $clog2(CLKS_PER_BIT);
   localparam logic [CW-1:0] BIT_LAST  = CW'(CLKS_PER_BIT - 1);
   localparam logic [CW-1:0] HALF_LAST = CW'(CLKS_PER_BIT / 2 - 1);

   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

   rx_state_t     state;
   logic [CW-1:0] cnt;       // clocks within the current bit
   logic [2:0]    bit_idx;
   logic          rx_meta;
   logic          rx_sync;
   logic [7:0]    shift_q;   // data bits, lsb arrives first

   assign rx_data = shift_q;

   // two flops on the async line, idle level is high
   always_ff @(posedge sys_clock or negedge rst_n) begin
      if (!rst_n) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end else begin
         rx_meta <= rx;
         rx_sync <= rx_meta;
      end
   end

   always_ff @(posedge sys_clock or negedge rst_n) begin
      if (!rst_n) begin
         state     <= RX_IDLE;
         cnt       <= '0;
         bit_idx   <= '0;
         rx_strobe <= 1'b0;
      end else begin
         rx_strobe <= 1'b0;
         case (state)
            RX_IDLE: begin
               cnt <= '0;
               if (!rx_sync) state <= RX_START;   // falling edge of start bit
            end
            RX_START: begin
               if (cnt == HALF_LAST) begin
                  cnt     <= '0;
                  bit_idx <= '0;
                  state   <= rx_sync ? RX_IDLE : RX_DATA;   // glitch check at mid start
               end else
                  cnt <= cnt + 1'b1;
            end
            RX_DATA: begin
               if (cnt == BIT_LAST) begin
                  cnt <= '0;
                  if (bit_idx == 3'd7) state <= RX_STOP;
                  bit_idx <= bit_idx + 1'b1;
               end else
                  cnt <= cnt + 1'b1;
            end
            default: begin   // RX_STOP
               if (cnt == BIT_LAST) begin
                  rx_strobe <= rx_sync;   // framing error drops the byte
                  state     <= RX_IDLE;
               end else
                  cnt <= cnt + 1'b1;
            end
         endcase
      end
   end

   // mid-bit sample into the shift register
   always_ff @(posedge sys_clock) begin
      if (state == RX_DATA && cnt == BIT_LAST)
         shift_q <= {rx_sync, shift_q[7:1]};
   end

endmodule : serial_rx

// File: rtl/serial_tx.sv
`timescale 1ns/100ps

module serial_tx #(
   parameter int CLKS_PER_BIT = 16
) (
   input  logic       sys_clock,
   input  logic       rst_n,
   input  logic [7:0] tx_data,
   input  logic       tx_start,   // one clock request
   input  logic       rx_busy,    // host buffer full, hold off new frames
   output logic       tx,
   output logic       tx_busy
);

   localparam int CW = $clog2(CLKS_PER_BIT);
   localparam logic [CW-1:0] BIT_LAST = CW'(CLKS_PER_BIT - 1);

   typedef enum logic [1:0] {TX_IDLE, TX_WAIT, TX_SEND} tx_state_t;

   tx_state_t     state;
   logic [CW-1:0] cnt;
   logic [3:0]    bit_idx;   // 0 start, 1..8 data, 9 stop
   logic [9:0]    frame_q;   // stop, data, start

   assign tx_busy = (state != TX_IDLE);

   // byte captured with its framing bits
   always_ff @(posedge sys_clock) begin
      if (state == TX_IDLE && tx_start)
         frame_q <= {1'b1, tx_data, 1'b0};
   end

   always_ff @(posedge sys_clock or negedge rst_n) begin
      if (!rst_n) begin
         state   <= TX_IDLE;
         cnt     <= '0;
         bit_idx <= '0;
         tx      <= 1'b1;   // line idles high
      end else begin
         case (state)
            TX_IDLE, TX_WAIT: begin
               cnt     <= '0;
               bit_idx <= '0;
               if ((state == TX_WAIT) || tx_start) begin
                  if (!rx_busy) begin
                     tx    <= 1'b0;   // start bit
                     state <= TX_SEND;
                  end else
                     state <= TX_WAIT;
               end
            end
            default: begin   // TX_SEND
               if (cnt == BIT_LAST) begin
                  cnt <= '0;
                  if (bit_idx == 4'd9) begin
                     state <= TX_IDLE;   // stop bit done, tx already high
                  end else begin
                     bit_idx <= bit_idx + 1'b1;
                     tx      <= frame_q[bit_idx + 4'd1];
                  end
               end else
                  cnt <= cnt + 1'b1;
            end
         endcase
      end
   end

endmodule : serial_tx

// File: rtl/vic_cfg_pkg.sv
package vic_cfg_pkg;

   // emulated chip model, matches the chip select value from the MCU
   typedef enum logic [1:0] {
      CHIP_6567R56A = 2'd0,   // early ntsc
      CHIP_6567R8   = 2'd1,   // ntsc
      CHIP_6569     = 2'd2,   // pal-b
      CHIP_6572     = 2'd3    // pal-n
   } chip_t;

   typedef logic [6:0] raster_x_t;   // cycle within a line
   typedef logic [8:0] raster_y_t;   // line within a frame
   typedef logic [6:0] reg_addr_t;   // register index from the command byte

   // raster windows
   localparam raster_x_t HSYNC_CYCLES   = 7'd4;
   localparam raster_y_t VSYNC_LINES    = 9'd3;
   localparam raster_x_t ACTIVE_X_FIRST = 7'd8;
   localparam raster_x_t ACTIVE_X_COUNT = 7'd40;
   localparam raster_y_t ACTIVE_Y_FIRST = 9'd16;
   localparam raster_y_t ACTIVE_Y_COUNT = 9'd200;

   // register map
   localparam reg_addr_t REG_CHIP      = 7'd0;
   localparam reg_addr_t REG_RASTER_LO = 7'd1;
   localparam reg_addr_t REG_RASTER_HI = 7'd2;   // bit0 cmp[8], bit7 irq enable
   localparam reg_addr_t REG_IRQ       = 7'd3;   // bit0 pending, write 1 clears

   localparam int CMD_READ_BIT = 7;   // set in first byte for a read

   function automatic raster_x_t cycles_per_line(input chip_t c);
      case (c)
         CHIP_6567R56A: return 7'd64;
         CHIP_6567R8:   return 7'd65;
         CHIP_6569:     return 7'd63;
         default:       return 7'd65;   // 6572
      endcase
   endfunction

   function automatic raster_y_t lines_per_frame(input chip_t c);
      case (c)
         CHIP_6567R56A: return 9'd262;
         CHIP_6567R8:   return 9'd263;
         default:       return 9'd312;   // both pal variants
      endcase
   endfunction

endpackage : vic_cfg_pkg

// File: rtl/vic_link_top.sv
`timescale 1ns/100ps

module vic_link_top
   import vic_cfg_pkg::*;
#(
   parameter int CLKS_PER_BIT = 16   // sys_clock cycles per serial bit
) (
   input  logic sys_clock,
   input  logic rst_n,
   input  logic rx,        // from MCU
   input  logic rx_busy,   // MCU receive buffer full
   output logic tx,        // to MCU
   output logic hsync,
   output logic vsync,
   output logic active,
   output logic irq
);

   logic [7:0] rx_data;
   logic       rx_strobe;
   logic [7:0] tx_data;
   logic       tx_start;
   logic       tx_busy;
   chip_t      chip;
   raster_y_t  raster_cmp;
   logic       irq_pending_set;

   serial_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) serial_rx_i (
      .sys_clock (sys_clock),
      .rst_n     (rst_n),
      .rx        (rx),
      .rx_data   (rx_data),
      .rx_strobe (rx_strobe)
   );

   serial_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) serial_tx_i (
      .sys_clock (sys_clock),
      .rst_n     (rst_n),
      .tx_data   (tx_data),
      .tx_start  (tx_start),
      .rx_busy   (rx_busy),    // back-pressure straight from the host
      .tx        (tx),
      .tx_busy   (tx_busy)
   );

   cfg_regs cfg_regs_i (
      .sys_clock       (sys_clock),
      .rst_n           (rst_n),
      .rx_data         (rx_data),
      .rx_strobe       (rx_strobe),
      .tx_busy         (tx_busy),
      .irq_pending_set (irq_pending_set),
      .tx_data         (tx_data),
      .tx_start        (tx_start),
      .chip            (chip),
      .raster_cmp      (raster_cmp),
      .irq_en          (),              // enable only gates irq inside cfg_regs
      .irq             (irq)
   );

   raster_timing raster_timing_i (
      .sys_clock       (sys_clock),
      .rst_n           (rst_n),
      .chip            (chip),
      .raster_cmp      (raster_cmp),
      .hsync           (hsync),
      .vsync           (vsync),
      .active          (active),
      .irq_pending_set (irq_pending_set)
   );

endmodule : vic_link_top

// File: run_sim.sh
#!/usr/bin/env bash
# build the vic link testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f filelist.f --top-module tb_vic_link -Mdir obj_dir -o tb_vic_link
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_vic_link > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulator exited with status $status"
fi

if grep -q "Everything OK" "$LOG"; then
   echo "PASS"
   exit 0
else
   echo "FAIL"
   exit 1
fi

// File: sim/tb_vic_link.sv
`timescale 1ns/100ps

module tb_vic_link
   import vic_cfg_pkg::*;
();

   localparam int CLKS_PER_BIT = 8;
   localparam int CLK_PERIOD   = 8;           // ns
   localparam logic [31:0] SEED = 32'd7;
   localparam int NUM_CMDS     = 64;          // bound on serial commands in the run
   localparam int FRAME_WAITS  = 20;          // raster frames waited on, all steps together
   localparam int REPLY_CLOCKS = 30 * CLKS_PER_BIT;
   localparam int TIMEOUT_NS   = (NUM_CMDS * REPLY_CLOCKS + FRAME_WAITS * 65 * 312) * CLK_PERIOD;

   logic sys_clock;
   logic rst_n;
   logic rx;
   logic rx_busy;
   logic tx;
   logic hsync;
   logic vsync;
   logic active;
   logic irq;

   logic [31:0] lcg_state = SEED;
   logic [7:0]  reply_q[$];     // bytes decoded from tx by the monitor
   chip_t       model_chip;     // register model, masked to defined bits
   logic [7:0]  model_lo;
   logic [7:0]  model_hi;

   vic_link_top #(.CLKS_PER_BIT(CLKS_PER_BIT)) dut_i (
      .sys_clock (sys_clock),
      .rst_n     (rst_n),
      .rx        (rx),
      .rx_busy   (rx_busy),
      .tx        (tx),
      .hsync     (hsync),
      .vsync     (vsync),
      .active    (active),
      .irq       (irq)
   );

   always #(CLK_PERIOD / 2) sys_clock = ~sys_clock;

   function automatic int unsigned next_random();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return {17'd0, lcg_state[30:16]};   // low bits of an lcg cycle too fast
   endfunction

   // raster geometry per model
   function automatic raster_y_t line_clocks_for(input chip_t c);
      case (c)
         CHIP_6567R56A: return 9'd64;
         CHIP_6569:     return 9'd63;
         default:       return 9'd65;
      endcase
   endfunction

   function automatic raster_y_t frame_lines_for(input chip_t c);
      case (c)
         CHIP_6567R56A: return 9'd262;
         CHIP_6567R8:   return 9'd263;
         default:       return 9'd312;
      endcase
   endfunction

   // display clocks in one line, zero outside the vertical window
   function automatic raster_y_t active_clocks_for(input raster_y_t line);
      if (line >= ACTIVE_Y_FIRST && line < ACTIVE_Y_FIRST + ACTIVE_Y_COUNT)
         return raster_y_t'(ACTIVE_X_COUNT);
      else
         return '0;
   endfunction

   function automatic logic [7:0] expected_read(input reg_addr_t addr);
      case (addr)
         REG_CHIP:      return {6'd0, model_chip};
         REG_RASTER_LO: return model_lo;
         REG_RASTER_HI: return model_hi;
         default:       return 8'd0;
      endcase
   endfunction

   task automatic abort_run(input string what);
      $display("%s", what);
      $display("Something failed");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_byte(input string name, input logic [7:0] expected,
                             input logic [7:0] actual);
      if (actual !== expected)
         abort_run($sformatf("error %s: expected 0x%02h, actual 0x%02h", name, expected, actual));
   endtask

   task automatic check_count(input string name, input raster_y_t expected,
                              input raster_y_t actual);
      if (actual !== expected)
         abort_run($sformatf("error %s: expected %0d, actual %0d", name, expected, actual));
   endtask

   task automatic check_chip(input string name, input chip_t expected, input chip_t actual);
      if (actual !== expected)
         abort_run($sformatf("error %s: expected %s, actual %s", name, expected.name(),
                             actual.name()));
   endtask

   // every wait ends 1 ns past a rising edge, where inputs change and outputs are settled
   task automatic wait_clocks(input int n);
      repeat (n) @(posedge sys_clock);
      #1;
   endtask

   task automatic send_byte(input logic [7:0] b);
      rx = 1'b0;                    // start bit
      wait_clocks(CLKS_PER_BIT);
      for (int i = 0; i < 8; i++) begin
         rx = b[i];                 // lsb first
         wait_clocks(CLKS_PER_BIT);
      end
      rx = 1'b1;                    // stop bit
      wait_clocks(CLKS_PER_BIT);
      wait_clocks(2);               // short idle gap
   endtask

   task automatic recv_byte(output logic [7:0] b);
      do
         wait_clocks(1);
      while (tx !== 1'b0);
      wait_clocks(CLKS_PER_BIT / 2);   // middle of start bit
      if (tx !== 1'b0) abort_run("tx start bit too short");
      for (int i = 0; i < 8; i++) begin
         wait_clocks(CLKS_PER_BIT);
         b[i] = tx;
      end
      wait_clocks(CLKS_PER_BIT);
      if (tx !== 1'b1) abort_run("tx stop bit missing");
   endtask

   task automatic wait_reply(output logic [7:0] b);
      int waited;
      waited = 0;
      while (reply_q.size() == 0) begin
         if (waited >= REPLY_CLOCKS) abort_run("no reply byte on tx in time");
         wait_clocks(1);
         waited++;
      end
      b = reply_q.pop_front();
   endtask

   task automatic write_reg(input reg_addr_t addr, input logic [7:0] data);
      send_byte({1'b0, addr});
      send_byte(data);
      case (addr)
         REG_CHIP:      model_chip = chip_t'(data[1:0]);
         REG_RASTER_LO: model_lo = data;
         REG_RASTER_HI: model_hi = data & 8'h81;   // cmp bit 8 and irq enable only
         default: ;
      endcase
   endtask

   task automatic read_reg(input reg_addr_t addr, output logic [7:0] data);
      if (reply_q.size() != 0) abort_run("unexpected byte seen on tx");
      send_byte({1'b1, addr});
      wait_reply(data);
   endtask

   task automatic wait_vsync_rise();
      logic prev;
      logic seen;
      prev = vsync;
      seen = 1'b0;
      while (!seen) begin
         wait_clocks(1);
         seen = vsync && !prev;
         prev = vsync;
      end
   endtask

   task automatic wait_hsync_rises(input int n);
      int   count;
      logic prev;
      count = 0;
      prev  = hsync;
      while (count < n) begin
         wait_clocks(1);
         if (hsync && !prev) count++;
         prev = hsync;
      end
   endtask

   // call right at a vsync rise, runs to the next one
   task automatic check_frame(input chip_t model);
      raster_y_t lines;
      raster_y_t act_clocks;
      int        clocks;
      int        last_rise;
      logic      hs_prev;
      logic      vs_prev;
      logic      done;
      lines      = 9'd1;   // line 0 started with this vsync rise
      act_clocks = '0;
      clocks     = 0;
      last_rise  = 0;
      hs_prev    = hsync;
      vs_prev    = vsync;
      done       = 1'b0;
      while (!done) begin
         wait_clocks(1);
         clocks++;
         if (hsync && !hs_prev) begin
            check_count("line clocks", line_clocks_for(model), raster_y_t'(clocks - last_rise));
            check_count("active clocks in line", active_clocks_for(lines - 9'd1), act_clocks);
            last_rise  = clocks;
            act_clocks = '0;
            if (vsync && !vs_prev) done = 1'b1;
            else lines = lines + 9'd1;
         end
         if (active) act_clocks = act_clocks + 9'd1;   // counted into the line just begun
         hs_prev = hsync;
         vs_prev = vsync;
      end
      check_count("frame lines", frame_lines_for(model), lines);
   endtask

   task automatic count_lines_to_irq(output raster_y_t n);
      logic hs_prev;
      logic irq_prev;
      logic hit;
      n        = '0;
      hs_prev  = hsync;
      irq_prev = irq;
      hit      = 1'b0;
      while (!hit) begin
         wait_clocks(1);
         hit = irq && !irq_prev;   // irq trails the line's hsync rise by a clock
         if (!hit && hsync && !hs_prev) n = n + 9'd1;
         hs_prev  = hsync;
         irq_prev = irq;
      end
   endtask

   initial begin : watchdog
      #(TIMEOUT_NS);
      abort_run("watchdog timeout: the run took longer than its tests allow");
   end

   initial begin : tx_monitor
      logic [7:0] got;
      wait (rst_n === 1'b1);
      forever begin
         recv_byte(got);
         reply_q.push_back(got);
      end
   end

   initial begin : main
      logic [7:0]  got;
      logic [7:0]  data;
      reg_addr_t   addr;
      chip_t       model;
      raster_y_t   cmp;
      raster_y_t   seen;
      int unsigned span;
      sys_clock  = 1'b0;
      rst_n      = 1'b0;
      rx         = 1'b1;
      rx_busy    = 1'b0;
      model_chip = CHIP_6569;
      model_lo   = 8'd0;
      model_hi   = 8'd0;
      wait_clocks(2);
      rst_n = 1'b1;

      // reset values
      check_byte("tx idle after reset", 8'd1, {7'd0, tx});
      check_byte("irq after reset", 8'd0, {7'd0, irq});
      read_reg(REG_CHIP, got);
      check_chip("chip after reset", CHIP_6569, chip_t'(got[1:0]));
      read_reg(REG_RASTER_HI, got);
      check_byte("raster hi after reset", 8'd0, got);

      // random write then readback
      for (int i = 0; i < 20; i++) begin
         addr = reg_addr_t'(next_random() % 3);
         data = 8'(next_random());
         write_reg(addr, data);
         read_reg(addr, got);
         check_byte($sformatf("readback %0d of reg %0d", i, addr), expected_read(addr), got);
      end

      // geometry of every model, one full frame after the switch
      for (int i = 0; i < 4; i++) begin
         model = chip_t'(2'(i));
         write_reg(REG_CHIP, {6'd0, model});
         read_reg(REG_CHIP, got);
         check_chip("chip readback", model, chip_t'(got[1:0]));
         wait_vsync_rise();
         wait_vsync_rise();
         check_frame(model);
      end

      // raster compare irq, cmp kept a few lines clear of the frame end
      span = {23'd0, frame_lines_for(model_chip)} - 32'd8;
      cmp  = raster_y_t'(next_random() % span);
      write_reg(REG_RASTER_LO, cmp[7:0]);
      write_reg(REG_RASTER_HI, {1'b1, 6'd0, cmp[8]});
      wait_vsync_rise();
      wait_hsync_rises(int'(cmp) + 1);   // compare line just passed
      write_reg(REG_IRQ, 8'h01);
      check_byte("irq after first clear", 8'd0, {7'd0, irq});
      wait_vsync_rise();
      check_byte("irq at frame start", 8'd0, {7'd0, irq});
      count_lines_to_irq(seen);
      check_count("irq line", cmp, seen);
      write_reg(REG_IRQ, 8'h01);
      check_byte("irq after clear", 8'd0, {7'd0, irq});
      read_reg(REG_IRQ, got);
      check_byte("irq pending after clear", 8'd0, got);

      // back-pressure from the host
      addr    = reg_addr_t'(next_random() % 3);
      rx_busy = 1'b1;
      send_byte({1'b1, addr});
      repeat (40 * CLKS_PER_BIT) begin
         wait_clocks(1);
         if (tx !== 1'b1) abort_run("tx sent a start bit while rx_busy was high");
      end
      rx_busy = 1'b0;
      wait_reply(got);
      check_byte("read held by rx_busy", expected_read(addr), got);

      $display("Everything OK");
      $finish;
   end

endmodule : tb_vic_link
